// ==== logic/uartPkg.sv ====
////////////////////////////////////////
// UART receive frame definitions
// Bit timing, decoder states, byte record
////////////////////////////////////////
`default_nettype none

package uartPkg;

        localparam int dataBits   = 8;                  // Byte width
        localparam int clksPerBit = 4;                  // Data_Rdy cycles per serial bit
        localparam int halfBit    = clksPerBit / 2;     // Start bit checked at mid-bit
        localparam int timerBits  = $clog2(clksPerBit);
        localparam int indexBits  = $clog2(dataBits);

        // Decoder FSM states
        typedef enum logic [1:0] {
                rxIdle,                                 // Waiting for a falling edge
                rxStart,                                // Confirming the start bit
                rxData,                                 // Shifting data bits, LSB first
                rxStop                                  // Checking the stop bit
        } rxState;

        // One received byte
        typedef struct packed {
                logic [dataBits-1:0] data;
                logic                frameErr;          // Stop bit sampled low
        } rxByte;

endpackage

`default_nettype wire

// ==== logic/fifoPkg.sv ====
////////////////////////////////////////
// Receive FIFO sizing and status records
////////////////////////////////////////
`default_nettype none

package fifoPkg;

        localparam int fifoAddrBits = 4;
        localparam int fifoEntries  = 1 << fifoAddrBits;  // 16 entries
        localparam int halfMark     = fifoEntries / 2;    // halfFull sets at 8
        localparam int countBits    = fifoAddrBits + 1;   // Holds 0..16

        // Occupancy flags from the FIFO
        typedef struct packed {
                logic                 empty;
                logic                 halfFull;
                logic                 overflow;           // Last write was dropped
                logic [countBits-1:0] count;
        } fifoFlags;

        // Host-visible status word
        typedef struct packed {
                logic                 empty;
                logic                 halfFull;
                logic                 overflow;
                logic [countBits-1:0] count;
                logic                 frameErr;           // Sticky until clearErr
                logic                 lostData;           // Sticky until clearErr
        } rxStatusWord;

endpackage

`default_nettype wire

// ==== logic/uartRxDecode.sv ====
////////////////////////////////////////
// UART receive decoder
// Samples the serial line, emits one strobe per frame
////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module uartRxDecode (
        input  wire logic      Data_Rdy,
        input  wire logic      Pop_Data,
        input  wire logic      serialIn,
        output uartPkg::rxByte rxOut,
        output logic           byteValid,
        output logic           frameErrPulse
);

        import uartPkg::*;

        logic [2:0]           syncQ;                    // Two sync stages plus edge history
        logic                 lineIn;                   // Synchronized line level
        logic                 fallEdge;
        logic                 sampleNow;                // Bit sample point this cycle
        rxState               state;
        logic [timerBits-1:0] bitTimer;
        logic [indexBits-1:0] bitIndex;
        logic [dataBits-1:0]  shiftReg;

        assign lineIn   = syncQ[1];
        assign fallEdge = syncQ[2] & ~syncQ[1];

        // Half a bit into the start bit, then a full bit period per sample
        assign sampleNow = (state == rxStart) ? (bitTimer == timerBits'(halfBit - 1)) :
                                                (bitTimer == timerBits'(clksPerBit - 1));

        ////////////////////////////////////////
        // Line synchronizer
        ////////////////////////////////////////
        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        syncQ <= '1;                    // Line idles high
                end else begin
                        syncQ <= {syncQ[1:0], serialIn};
                end
        end

        ////////////////////////////////////////
        // Frame FSM
        ////////////////////////////////////////
        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        state         <= rxIdle;
                        bitTimer      <= '0;
                        bitIndex      <= '0;
                        byteValid     <= 1'b0;
                        frameErrPulse <= 1'b0;
                end else begin
                        byteValid     <= 1'b0;          // Strobes last one cycle
                        frameErrPulse <= 1'b0;
                        bitTimer      <= sampleNow ? '0 : bitTimer + 1'b1;
                        case (state)
                                rxIdle: begin
                                        bitTimer <= '0; // Timer starts at the edge
                                        if (fallEdge) begin
                                                state <= rxStart;
                                        end
                                end
                                rxStart: begin
                                        if (sampleNow) begin
                                                // High again means a glitch
                                                state <= lineIn ? rxIdle : rxData;
                                        end
                                end
                                rxData: begin
                                        if (sampleNow) begin
                                                bitIndex <= bitIndex + 1'b1;   // Wraps to 0
                                                if (bitIndex == indexBits'(dataBits - 1)) begin
                                                        state <= rxStop;
                                                end
                                        end
                                end
                                rxStop: begin
                                        if (sampleNow) begin
                                                state         <= rxIdle;
                                                byteValid     <= lineIn;       // Good stop bit
                                                frameErrPulse <= ~lineIn;
                                        end
                                end
                                default: state <= rxIdle;
                        endcase
                end
        end

        // Shift register and byte output
        always_ff @(posedge Data_Rdy) begin
                if (state == rxData && sampleNow) begin
                        shiftReg <= {lineIn, shiftReg[dataBits-1:1]};   // LSB arrives first
                end
                if (state == rxStop && sampleNow) begin
                        rxOut.data     <= shiftReg;
                        rxOut.frameErr <= ~lineIn;
                end
        end

endmodule

`default_nettype wire

// ==== logic/rxFifo.sv ====
////////////////////////////////////////
// Receive byte FIFO, 16 entries
// Occupancy flags, drop on full, self-test freeze
////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module rxFifo (
        input  wire logic                         Data_Rdy,
        input  wire logic                         Pop_Data,
        input  wire logic [uartPkg::dataBits-1:0] wrData,
        input  wire logic                         byteValid,
        input  wire logic                         popReq,
        input  wire logic                         bistMode,
        output logic [uartPkg::dataBits-1:0]      rxData,
        output fifoPkg::fifoFlags                 flags,
        output logic                              dropPulse
);

        import uartPkg::*;
        import fifoPkg::*;

        logic [dataBits-1:0]     mem [fifoEntries];     // Byte storage
        logic [fifoAddrBits-1:0] wrPtr;
        logic [fifoAddrBits-1:0] rdPtr;
        logic                    full;
        logic                    doWr;                  // Accepted write
        logic                    doRd;                  // Accepted pop
        logic                    dropNow;               // Write refused while full
        logic [countBits-1:0]    countNext;

        assign full    = (flags.count == countBits'(fifoEntries));
        assign doWr    = byteValid & ~bistMode & ~full;
        assign dropNow = byteValid & ~bistMode & full;
        assign doRd    = popReq & ~bistMode & (flags.count != '0);   // Empty pop ignored

        // Write and pop together leave count unchanged
        assign countNext = flags.count + countBits'(doWr) - countBits'(doRd);

        ////////////////////////////////////////
        // Storage
        ////////////////////////////////////////
        always_ff @(posedge Data_Rdy) begin
                if (doWr) begin
                        mem[wrPtr] <= wrData;
                end
        end

        ////////////////////////////////////////
        // Pointers, read data and flags
        ////////////////////////////////////////
        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        wrPtr          <= '0;
                        rdPtr          <= '0;
                        rxData         <= '0;
                        dropPulse      <= 1'b0;
                        flags.empty    <= 1'b1;
                        flags.halfFull <= 1'b0;
                        flags.overflow <= 1'b0;
                        flags.count    <= '0;
                end else begin
                        dropPulse <= dropNow;
                        if (doWr) begin
                                wrPtr <= wrPtr + 1'b1;  // Wraps at 16
                        end
                        if (doRd) begin
                                rdPtr  <= rdPtr + 1'b1;
                                rxData <= mem[rdPtr];   // Held until the next pop
                        end

                        // Flags follow the next count and hold in self-test
                        flags.count    <= countNext;
                        flags.empty    <= (countNext == '0);
                        flags.halfFull <= (countNext >= countBits'(halfMark));

                        // A new drop wins over a pop in the same cycle
                        if (dropNow) begin
                                flags.overflow <= 1'b1;
                        end else if (doRd) begin
                                flags.overflow <= 1'b0;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== logic/rxStatus.sv ====
////////////////////////////////////////
// Receive status register
// Registered FIFO flags plus sticky errors
////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module rxStatus (
        input  wire logic              Data_Rdy,
        input  wire logic              Pop_Data,
        input  wire fifoPkg::fifoFlags flags,
        input  wire logic              frameErrPulse,
        input  wire logic              dropPulse,
        input  wire logic              clearErr,
        output fifoPkg::rxStatusWord   status
);

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        status.empty    <= 1'b1;        // Empty FIFO after reset
                        status.halfFull <= 1'b0;
                        status.overflow <= 1'b0;
                        status.count    <= '0;
                        status.frameErr <= 1'b0;
                        status.lostData <= 1'b0;
                end else begin
                        // Flags trail the FIFO by one cycle
                        status.empty    <= flags.empty;
                        status.halfFull <= flags.halfFull;
                        status.overflow <= flags.overflow;
                        status.count    <= flags.count;

                        // Set pulse beats a clear in the same cycle
                        status.frameErr <= frameErrPulse | (status.frameErr & ~clearErr);
                        status.lostData <= dropPulse | (status.lostData & ~clearErr);
                end
        end

endmodule

`default_nettype wire

// ==== logic/uartRxTop.sv ====
////////////////////////////////////////
// UART receive subsystem top
// Decoder, byte FIFO and status register
////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module uartRxTop (
        input  wire logic                    Data_Rdy,
        input  wire logic                    Pop_Data,
        input  wire logic                    serialIn,   // Idles high
        input  wire logic                    popReq,     // One-cycle pulse
        input  wire logic                    bistMode,   // Level, freezes the FIFO
        input  wire logic                    clearErr,   // One-cycle pulse
        output logic [uartPkg::dataBits-1:0] rxData,
        output fifoPkg::rxStatusWord         status
);

        import uartPkg::*;
        import fifoPkg::*;

        rxByte    rxOut;                                // Decoded byte
        logic     byteValid;                            // Good frame strobe
        logic     frameErrPulse;                        // Bad stop bit strobe
        logic     dropPulse;                            // Byte lost on full FIFO
        fifoFlags flags;

        ////////////////////////////////////////
        // Decode, execute, result
        ////////////////////////////////////////
        uartRxDecode u_decode (
                .Data_Rdy      (Data_Rdy),
                .Pop_Data      (Pop_Data),
                .serialIn      (serialIn),
                .rxOut         (rxOut),
                .byteValid     (byteValid),
                .frameErrPulse (frameErrPulse)
        );

        rxFifo u_fifo (
                .Data_Rdy  (Data_Rdy),
                .Pop_Data  (Pop_Data),
                .wrData    (rxOut.data),                // Bad frames never strobe
                .byteValid (byteValid),
                .popReq    (popReq),
                .bistMode  (bistMode),
                .rxData    (rxData),
                .flags     (flags),
                .dropPulse (dropPulse)
        );

        rxStatus u_status (
                .Data_Rdy      (Data_Rdy),
                .Pop_Data      (Pop_Data),
                .flags         (flags),
                .frameErrPulse (frameErrPulse),
                .dropPulse     (dropPulse),
                .clearErr      (clearErr),
                .status        (status)
        );

endmodule

`default_nettype wire

// ==== verification/tbUartRx.sv ====
////////////////////////////////////////
// Testbench for the UART receive top
// Table of frames, pops and self-test steps
////////////////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module tbUartRx;

        import uartPkg::*;
        import fifoPkg::*;

        localparam int          clkPeriodNs = 40;
        localparam int          resetCycles = 10;
        localparam int          bitPeriodNs = clksPerBit * clkPeriodNs;
        localparam int          rowBudgetNs = 12 * bitPeriodNs;   // 48 cycles per repeat
        localparam int          idleCycles  = 4;                  // Settling after a frame
        localparam logic [15:0] lfsrSeed    = 16'd36316;
        localparam int          numRows     = 23;

        typedef enum logic [2:0] {
                opSendBytes,
                opSendBadStop,
                opPop,
                opBistOn,
                opBistOff,
                opClear
        } testOp;

        // One table row with the status expected after it
        typedef struct packed {
                testOp       op;
                logic [15:0] reps;
                rxStatusWord expStatus;
        } testRow;

        logic                Data_Rdy = 1'b0;
        logic                Pop_Data;
        logic                serialIn;
        logic                popReq;
        logic                bistMode;
        logic                clearErr;
        logic [dataBits-1:0] rxData;
        rxStatusWord         status;

        testRow              rowTable [numRows];
        string               rowName  [numRows];
        int                  rowCount;
        logic                tableReady;
        logic [15:0]         lfsrState;
        logic [dataBits-1:0] modelQ [$];                // Bytes the FIFO should hold
        logic [dataBits-1:0] lastPopped;                // Expected rxData
        logic                bistActive;                // Model freeze
        int                  errorCount;
        int                  checkCount;

        uartRxTop u_dut (
                .Data_Rdy (Data_Rdy),
                .Pop_Data (Pop_Data),
                .serialIn (serialIn),
                .popReq   (popReq),
                .bistMode (bistMode),
                .clearErr (clearErr),
                .rxData   (rxData),
                .status   (status)
        );

        always #(clkPeriodNs / 2) Data_Rdy = ~Data_Rdy;

        ////////////////////////////////////////
        // Random bytes and checking
        ////////////////////////////////////////
        // Taps 16, 14, 13, 11
        function automatic logic [15:0] lfsrStep(input logic [15:0] s);
                return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        endfunction

        task automatic nextRandomByte(output logic [dataBits-1:0] b);
                int i;
                for (i = 0; i < dataBits; i++) begin
                        lfsrState = lfsrStep(lfsrState);   // One step per bit
                        b[i]      = lfsrState[0];
                end
        endtask

        task automatic checkValue(input string testName, input string what,
                                  input int expected, input int actual);
                checkCount++;
                assert (actual == expected) else begin
                        $display("ERR %s %s expected 0x%0h actual 0x%0h",
                                 testName, what, expected, actual);
                        errorCount++;
                end
        endtask

        task automatic checkStatus(input string nm, input rxStatusWord exp);
                checkValue(nm, "count", int'(exp.count), int'(status.count));
                checkValue(nm, "empty", int'(exp.empty), int'(status.empty));
                checkValue(nm, "halfFull", int'(exp.halfFull), int'(status.halfFull));
                checkValue(nm, "overflow", int'(exp.overflow), int'(status.overflow));
                checkValue(nm, "frameErr", int'(exp.frameErr), int'(status.frameErr));
                checkValue(nm, "lostData", int'(exp.lostData), int'(status.lostData));
                checkValue(nm, "rxData", int'(lastPopped), int'(rxData));
        endtask

        ////////////////////////////////////////
        // Bus-level drivers
        ////////////////////////////////////////
        task automatic driveBit(input logic v);
                @(posedge Data_Rdy);
                serialIn <= v;
                repeat (clksPerBit - 1) @(posedge Data_Rdy);   // Hold one bit period
        endtask

        task automatic sendFrame(input logic [dataBits-1:0] b, input logic badStop);
                int i;
                driveBit(1'b0);                                 // Start bit
                for (i = 0; i < dataBits; i++) begin
                        driveBit(b[i]);                         // LSB first
                end
                driveBit(~badStop);
                @(posedge Data_Rdy);
                serialIn <= 1'b1;                               // Line back to idle
                repeat (idleCycles) @(posedge Data_Rdy);
        endtask

        task automatic popOnce(input string nm);
                @(posedge Data_Rdy);
                popReq <= 1'b1;
                @(posedge Data_Rdy);
                popReq <= 1'b0;
                repeat (2) @(posedge Data_Rdy);
                @(negedge Data_Rdy);
                // Frozen or empty FIFO keeps the old byte
                if (!bistActive && modelQ.size() > 0) begin
                        lastPopped = modelQ.pop_front();
                end
                checkValue(nm, "popped rxData", int'(lastPopped), int'(rxData));
        endtask

        task automatic pulseClear();
                @(posedge Data_Rdy);
                clearErr <= 1'b1;
                @(posedge Data_Rdy);
                clearErr <= 1'b0;
                repeat (2) @(posedge Data_Rdy);
        endtask

        task automatic setBist(input logic level);
                @(posedge Data_Rdy);
                bistMode   <= level;
                bistActive = level;
                repeat (2) @(posedge Data_Rdy);
        endtask

        ////////////////////////////////////////
        // Test table
        ////////////////////////////////////////
        task automatic addRow(input string nm, input testOp op, input int reps,
                              input int cnt, input int emp, input int half,
                              input int ovf, input int fe, input int lost);
                rowName[rowCount]                     = nm;
                rowTable[rowCount].op                 = op;
                rowTable[rowCount].reps               = 16'(reps);
                rowTable[rowCount].expStatus.count    = countBits'(cnt);
                rowTable[rowCount].expStatus.empty    = (emp != 0);
                rowTable[rowCount].expStatus.halfFull = (half != 0);
                rowTable[rowCount].expStatus.overflow = (ovf != 0);
                rowTable[rowCount].expStatus.frameErr = (fe != 0);
                rowTable[rowCount].expStatus.lostData = (lost != 0);
                rowCount++;
        endtask

        task automatic loadTable();
                rowCount = 0;
                //     name            op             reps cnt emp half ovf fe lost
                addRow("resetState",   opClear,       0,   0,  1,  0,   0,  0, 0);
                addRow("orderSend5",   opSendBytes,   5,   5,  0,  0,   0,  0, 0);
                addRow("orderPop5",    opPop,         5,   0,  1,  0,   0,  0, 0);
                addRow("halfSend7",    opSendBytes,   7,   7,  0,  0,   0,  0, 0);
                addRow("halfSend8th",  opSendBytes,   1,   8,  0,  1,   0,  0, 0);
                addRow("halfPop1",     opPop,         1,   7,  0,  0,   0,  0, 0);
                addRow("drainHalf",    opPop,         7,   0,  1,  0,   0,  0, 0);
                addRow("fillTo16",     opSendBytes,   16,  16, 0,  1,   0,  0, 0);
                addRow("send17th",     opSendBytes,   1,   16, 0,  1,   1,  0, 1);
                addRow("ovfPop1",      opPop,         1,   15, 0,  1,   0,  0, 1);
                addRow("drainFull",    opPop,         15,  0,  1,  0,   0,  0, 1);
                addRow("clearLost",    opClear,       1,   0,  1,  0,   0,  0, 0);
                addRow("badStop",      opSendBadStop, 1,   0,  1,  0,   0,  1, 0);
                addRow("goodAfterBad", opSendBytes,   2,   2,  0,  0,   0,  1, 0);
                addRow("clearFrame",   opClear,       1,   2,  0,  0,   0,  0, 0);
                addRow("drainTwo",     opPop,         2,   0,  1,  0,   0,  0, 0);
                addRow("preBist",      opSendBytes,   1,   1,  0,  0,   0,  0, 0);
                addRow("bistOn",       opBistOn,      1,   1,  0,  0,   0,  0, 0);
                addRow("bistSend3",    opSendBytes,   3,   1,  0,  0,   0,  0, 0);
                addRow("bistPop2",     opPop,         2,   1,  0,  0,   0,  0, 0);
                addRow("bistOff",      opBistOff,     1,   1,  0,  0,   0,  0, 0);
                addRow("postBist",     opSendBytes,   1,   2,  0,  0,   0,  0, 0);
                addRow("postBistPop",  opPop,         2,   0,  1,  0,   0,  0, 0);
                tableReady = 1'b1;
        endtask

        task automatic runRow(input int idx);
                logic [dataBits-1:0] b;
                int                  n;
                for (n = 0; n < int'(rowTable[idx].reps); n++) begin
                        case (rowTable[idx].op)
                                opSendBytes: begin
                                        nextRandomByte(b);
                                        sendFrame(b, 1'b0);
                                        // Full or frozen FIFO loses the byte
                                        if (!bistActive && modelQ.size() < fifoEntries) begin
                                                modelQ.push_back(b);
                                        end
                                end
                                opSendBadStop: begin
                                        nextRandomByte(b);
                                        sendFrame(b, 1'b1);     // Never stored
                                end
                                opPop:     popOnce(rowName[idx]);
                                opBistOn:  setBist(1'b1);
                                opBistOff: setBist(1'b0);
                                opClear:   pulseClear();
                                default:   ;
                        endcase
                end
                @(negedge Data_Rdy);                            // Sample away from the edge
                checkStatus(rowName[idx], rowTable[idx].expStatus);
        endtask

        ////////////////////////////////////////
        // Main sequence
        ////////////////////////////////////////
        initial begin
                int errBefore;
                int passedRows;
                int i;
                Pop_Data   <= 1'b1;
                serialIn   <= 1'b1;                     // Idle line
                popReq     <= 1'b0;
                bistMode   <= 1'b0;
                clearErr   <= 1'b0;
                lfsrState  = lfsrSeed;
                lastPopped = '0;                        // rxData resets to 0
                bistActive = 1'b0;
                errorCount = 0;
                checkCount = 0;
                passedRows = 0;
                loadTable();
                repeat (resetCycles) @(posedge Data_Rdy);
                Pop_Data <= 1'b0;
                repeat (2) @(posedge Data_Rdy);

                for (i = 0; i < rowCount; i++) begin
                        errBefore = errorCount;
                        runRow(i);
                        if (errorCount == errBefore) begin
                                passedRows++;
                                $display("test %s ok", rowName[i]);
                        end else begin
                                $display("test %s FAILED with %0d errors",
                                         rowName[i], errorCount - errBefore);
                        end
                end

                $display("Summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                         rowCount, passedRows, rowCount - passedRows, checkCount, errorCount);
                if (errorCount == 0) begin
                        $display("Regression passed");
                end else begin
                        $display("Regression failed");
                end
                $finish;
        end

        // Watchdog limited to twice the reset and table budget
        initial begin
                longint limitNs;
                int     i;
                wait (tableReady === 1'b1);
                limitNs = longint'(resetCycles) * clkPeriodNs;
                for (i = 0; i < rowCount; i++) begin
                        limitNs += longint'(rowTable[i].reps) * rowBudgetNs;
                end
                limitNs *= 2;
                #(limitNs);
                $display("Timeout: the test table did not finish within %0d ns", limitNs);
                $display("Regression failed");
                $finish;
        end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/uartPkg.sv
logic/fifoPkg.sv
logic/uartRxDecode.sv
logic/rxFifo.sv
logic/rxStatus.sv
logic/uartRxTop.sv
verification/tbUartRx.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the UART receive regression with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
        --timescale 1ns/10ps \
        --top-module tbUartRx \
        -f sim.f \
        -o simUartRx

simOut=$(./obj_dir/simUartRx)
echo "$simOut"

if echo "$simOut" | grep -qx "Regression passed"; then
        exit 0
else
        exit 1
fi
